// File: src/mmu_pkg.sv
package mmu_pkg;

    // basic widths
    localparam int WORD_W   = 32;
    localparam int VPN2_W   = 19;
    localparam int PFN_W    = 20;
    localparam int ASID_W   = 8;
    localparam int OFFSET_W = 12;   // 4 KiB pages
    localparam int CATTR_W  = 3;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [VPN2_W-1:0]  vpn2_t;   // even/odd page pair
    typedef logic [PFN_W-1:0]   pfn_t;
    typedef logic [ASID_W-1:0]  asid_t;
    typedef logic [CATTR_W-1:0] cattr_t;

    // one TLB entry maps a pair of pages
    typedef struct packed {
        vpn2_t  vpn2;
        asid_t  asid;
        logic   g;      // global, ignores asid
        pfn_t   pfn0;
        cattr_t c0;
        logic   v0;
        pfn_t   pfn1;
        cattr_t c1;
        logic   v1;
    } tlb_entry_t;

    // TLB maintenance operations from the core
    typedef enum logic [1:0] {
        TLB_NOP   = 2'd0,
        TLB_PROBE = 2'd1,
        TLB_READ  = 2'd2,
        TLB_WRITE = 2'd3
    } tlb_op_e;

    localparam int TLB_ENTRIES_DEFAULT = 8;

    // cache attribute for cacheable, noncoherent
    localparam cattr_t K0_CACHED = 3'd3;

    // segment decode, on vaddr[31:29]
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // unmapped segments just drop the top three bits
    function automatic word_t seg_strip(word_t vaddr);
        word_t p;
        p = vaddr;
        p[WORD_W-1 -: 3] = 3'b000;
        return p;
    endfunction

endpackage

// File: src/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;
    import mmu_pkg::*;

    logic       req;
    logic       wr;
    logic [1:0] size;       // 0 byte, 1 half, 2 word
    word_t      addr;
    word_t      wdata;

    logic       addr_ok;    // request accepted this cycle
    logic       data_ok;    // one pulse per accepted request, in order
    word_t      rdata;

    modport master (
        output req, wr, size, addr, wdata,
        input  addr_ok, data_ok, rdata
    );

    modport slave (
        input  req, wr, size, addr, wdata,
        output addr_ok, data_ok, rdata
    );

endinterface

// File: src/tlb.sv
`timescale 1ns/1ns

module tlb #(
    parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES_DEFAULT
) (
    input  logic                           clk,
    input  logic                           resetn,

    // lookup ports, instruction and data
    input  mmu_pkg::vpn2_t                 i_ilook_vpn2,
    input  mmu_pkg::vpn2_t                 i_dlook_vpn2,
    input  mmu_pkg::asid_t                 i_asid,
    output logic                           o_ihit,
    output logic                           o_dhit,
    output mmu_pkg::tlb_entry_t            o_ientry,
    output mmu_pkg::tlb_entry_t            o_dentry,

    // maintenance op port
    input  mmu_pkg::tlb_op_e               i_op,
    input  logic [$clog2(TLB_ENTRIES)-1:0] i_op_index,
    input  mmu_pkg::tlb_entry_t            i_op_entry,
    output logic                           o_tlbp_found,
    output logic [$clog2(TLB_ENTRIES)-1:0] o_tlbp_index,
    output mmu_pkg::tlb_entry_t            o_tlbr_entry
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    tlb_entry_t       entries [TLB_ENTRIES];
    logic             probe_hit;
    logic [IDX_W-1:0] probe_idx;

    function automatic logic entry_match(tlb_entry_t e, vpn2_t vpn2, asid_t asid);
        return (e.vpn2 == vpn2) && (e.g || e.asid == asid);
    endfunction

    // both lookups in parallel, fully associative
    always_comb begin
        o_ihit   = 1'b0;
        o_dhit   = 1'b0;
        o_ientry = '0;
        o_dentry = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entry_match(entries[i], i_ilook_vpn2, i_asid)) begin
                o_ihit   = 1'b1;
                o_ientry = entries[i];
            end
            if (entry_match(entries[i], i_dlook_vpn2, i_asid)) begin
                o_dhit   = 1'b1;
                o_dentry = entries[i];
            end
        end
    end

    // probe key comes from the op entry, not the lookup ports
    always_comb begin
        probe_hit = 1'b0;
        probe_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entry_match(entries[i], i_op_entry.vpn2, i_op_entry.asid)) begin
                probe_hit = 1'b1;
                probe_idx = IDX_W'(i);
            end
        end
    end

    // entry array, written whole
    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;   // clears v0, v1 and g
            end
        end else if (i_op == TLB_WRITE) begin
            entries[i_op_index] <= i_op_entry;
        end
    end

    // op results hold until the next op of the same kind
    always_ff @(posedge clk) begin
        if (resetn) begin
            o_tlbp_found <= 1'b0;
            o_tlbp_index <= '0;
            o_tlbr_entry <= '0;
        end else begin
            case (i_op)
                TLB_PROBE: begin
                    o_tlbp_found <= probe_hit;
                    o_tlbp_index <= probe_idx;
                end
                TLB_READ:  o_tlbr_entry <= entries[i_op_index];
                default: ;
            endcase
        end
    end

endmodule

// File: src/addr_translate.sv
`timescale 1ns/1ns

module addr_translate (
    input  mmu_pkg::word_t      i_vaddr,
    input  logic                i_k0_uncached,
    input  logic                i_hit,          // from the TLB lookup on o_vpn2
    input  mmu_pkg::tlb_entry_t i_entry,
    output mmu_pkg::vpn2_t      o_vpn2,
    output mmu_pkg::word_t      o_paddr,
    output logic                o_uncached,
    output logic                o_miss
);
    import mmu_pkg::*;

    logic [2:0] seg;
    pfn_t       page_pfn;
    cattr_t     page_c;
    logic       page_v;

    assign seg    = i_vaddr[31:29];
    assign o_vpn2 = i_vaddr[31:13];

    // vaddr bit 12 picks the even or odd half of the pair
    always_comb begin
        if (i_vaddr[12]) begin
            page_pfn = i_entry.pfn1;
            page_c   = i_entry.c1;
            page_v   = i_entry.v1;
        end else begin
            page_pfn = i_entry.pfn0;
            page_c   = i_entry.c0;
            page_v   = i_entry.v0;
        end
    end

    always_comb begin
        o_paddr    = seg_strip(i_vaddr);    // unmapped / fallback address
        o_uncached = 1'b1;
        o_miss     = 1'b0;

        case (seg)
            SEG_KSEG0: o_uncached = i_k0_uncached;
            SEG_KSEG1: o_uncached = 1'b1;
            default: begin
                // mapped segments go through the TLB
                if (i_hit && page_v) begin
                    o_paddr    = {page_pfn, i_vaddr[OFFSET_W-1:0]};
                    o_uncached = (page_c != K0_CACHED);
                end else begin
                    o_miss = 1'b1;  // forwarded anyway, uncached
                end
            end
        endcase
    end

endmodule

// File: src/dmem_dispatch.sv
`timescale 1ns/1ns

module dmem_dispatch (
    input  logic           clk,
    input  logic           resetn,
    mem_bus_if.slave       cpu,
    mem_bus_if.master      dcache,
    mem_bus_if.master      uncached,
    input  mmu_pkg::word_t i_paddr,     // translated cpu.addr
    input  logic           i_uncached
);
    import mmu_pkg::*;

    // pipeline state
    logic cur_finished;     // stage 1 already got addr_ok
    logic last_finished;    // stage 2 already got data_ok, i.e. empty
    logic last_uncached;    // target of stage 2

    logic real_addr_ok;
    logic data_ok;
    logic last_ready;
    logic cur_ready;
    logic req_ready;
    logic req_live;

    assign real_addr_ok = i_uncached ? uncached.addr_ok : dcache.addr_ok;
    assign data_ok      = last_uncached ? uncached.data_ok : dcache.data_ok;

    assign last_ready = last_finished || data_ok;           // stage 2 frees up this cycle
    assign cur_ready  = last_ready && (cur_finished || real_addr_ok);
    assign req_ready  = (i_uncached == last_uncached) || last_finished;   // no target switch
                                                            // while older data pending

    // masked once the target took the address
    assign req_live = cpu.req && req_ready && !cur_finished;

    assign dcache.req   = req_live && !i_uncached;
    assign dcache.wr    = cpu.wr;
    assign dcache.size  = cpu.size;
    assign dcache.addr  = i_paddr;
    assign dcache.wdata = cpu.wdata;

    assign uncached.req   = req_live && i_uncached;
    assign uncached.wr    = cpu.wr;
    assign uncached.size  = cpu.size;
    assign uncached.addr  = i_paddr;
    assign uncached.wdata = cpu.wdata;

    // responses come from whoever owns stage 2
    assign cpu.addr_ok = cur_ready && req_ready;
    assign cpu.data_ok = data_ok;
    assign cpu.rdata   = last_uncached ? uncached.rdata : dcache.rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            cur_finished  <= 1'b0;
            last_finished <= 1'b1;
            last_uncached <= 1'b0;
        end else begin
            if (!last_finished) begin
                last_finished <= data_ok;
            end

            if (cpu.req && req_ready) begin
                if (cur_ready) begin
                    // stage 1 moves into stage 2
                    cur_finished  <= 1'b0;
                    last_finished <= 1'b0;
                    last_uncached <= i_uncached;
                end else if (!cur_finished) begin
                    cur_finished <= real_addr_ok;   // accepted, stage 2 still busy
                end
            end
        end
    end

endmodule

// File: src/mmu_top.sv
`timescale 1ns/1ns

module mmu_top #(
    parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES_DEFAULT
) (
    input  logic                           clk,
    input  logic                           resetn,

    // cpu instruction bus
    input  logic                           i_ireq,
    input  mmu_pkg::word_t                 i_iaddr,
    output logic                           o_iaddr_ok,
    output logic                           o_idata_ok,
    output mmu_pkg::word_t                 o_irdata,

    // cpu data bus
    input  logic                           i_dreq,
    input  logic                           i_dwr,
    input  logic [1:0]                     i_dsize,
    input  mmu_pkg::word_t                 i_daddr,
    input  mmu_pkg::word_t                 i_dwdata,
    output logic                           o_daddr_ok,
    output logic                           o_ddata_ok,
    output mmu_pkg::word_t                 o_drdata,

    // icache
    output logic                           o_ic_req,
    output mmu_pkg::word_t                 o_ic_addr,
    input  logic                           i_ic_addr_ok,
    input  logic                           i_ic_data_ok,
    input  mmu_pkg::word_t                 i_ic_rdata,

    // dcache
    output logic                           o_dc_req,
    output logic                           o_dc_wr,
    output logic [1:0]                     o_dc_size,
    output mmu_pkg::word_t                 o_dc_addr,
    output mmu_pkg::word_t                 o_dc_wdata,
    input  logic                           i_dc_addr_ok,
    input  logic                           i_dc_data_ok,
    input  mmu_pkg::word_t                 i_dc_rdata,

    // uncached
    output logic                           o_uc_req,
    output logic                           o_uc_wr,
    output logic [1:0]                     o_uc_size,
    output mmu_pkg::word_t                 o_uc_addr,
    output mmu_pkg::word_t                 o_uc_wdata,
    input  logic                           i_uc_addr_ok,
    input  logic                           i_uc_data_ok,
    input  mmu_pkg::word_t                 i_uc_rdata,

    // TLB ops
    input  mmu_pkg::asid_t                 i_asid,
    input  mmu_pkg::tlb_op_e               i_tlb_op,
    input  logic [$clog2(TLB_ENTRIES)-1:0] i_tlb_index,
    input  mmu_pkg::tlb_entry_t            i_tlb_entry,
    output logic                           o_tlbp_found,
    output logic [$clog2(TLB_ENTRIES)-1:0] o_tlbp_index,
    output mmu_pkg::tlb_entry_t            o_tlbr_entry,

    output logic                           o_imiss,
    output logic                           o_dmiss,
    input  logic                           i_k0_uncached
);
    import mmu_pkg::*;

    vpn2_t      ivpn2, dvpn2;
    logic       ihit, dhit;
    tlb_entry_t ientry, dentry;
    word_t      dpaddr;
    logic       duncached;

    mem_bus_if d_cpu ();
    mem_bus_if d_cache ();
    mem_bus_if d_unc ();

    // data side plain ports onto the internal buses
    assign d_cpu.req   = i_dreq;
    assign d_cpu.wr    = i_dwr;
    assign d_cpu.size  = i_dsize;
    assign d_cpu.addr  = i_daddr;
    assign d_cpu.wdata = i_dwdata;
    assign o_daddr_ok  = d_cpu.addr_ok;
    assign o_ddata_ok  = d_cpu.data_ok;
    assign o_drdata    = d_cpu.rdata;

    assign o_dc_req          = d_cache.req;
    assign o_dc_wr           = d_cache.wr;
    assign o_dc_size         = d_cache.size;
    assign o_dc_addr         = d_cache.addr;
    assign o_dc_wdata        = d_cache.wdata;
    assign d_cache.addr_ok   = i_dc_addr_ok;
    assign d_cache.data_ok   = i_dc_data_ok;
    assign d_cache.rdata     = i_dc_rdata;

    assign o_uc_req        = d_unc.req;
    assign o_uc_wr         = d_unc.wr;
    assign o_uc_size       = d_unc.size;
    assign o_uc_addr       = d_unc.addr;
    assign o_uc_wdata      = d_unc.wdata;
    assign d_unc.addr_ok   = i_uc_addr_ok;
    assign d_unc.data_ok   = i_uc_data_ok;
    assign d_unc.rdata     = i_uc_rdata;

    // instruction bus passes through, only the address is translated
    assign o_ic_req   = i_ireq;
    assign o_iaddr_ok = i_ic_addr_ok;
    assign o_idata_ok = i_ic_data_ok;
    assign o_irdata   = i_ic_rdata;

    tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk          (clk),
        .resetn       (resetn),
        .i_ilook_vpn2 (ivpn2),
        .i_dlook_vpn2 (dvpn2),
        .i_asid       (i_asid),
        .o_ihit       (ihit),
        .o_dhit       (dhit),
        .o_ientry     (ientry),
        .o_dentry     (dentry),
        .i_op         (i_tlb_op),
        .i_op_index   (i_tlb_index),
        .i_op_entry   (i_tlb_entry),
        .o_tlbp_found (o_tlbp_found),
        .o_tlbp_index (o_tlbp_index),
        .o_tlbr_entry (o_tlbr_entry)
    );

    addr_translate u_itrans (
        .i_vaddr       (i_iaddr),
        .i_k0_uncached (i_k0_uncached),
        .i_hit         (ihit),
        .i_entry       (ientry),
        .o_vpn2        (ivpn2),
        .o_paddr       (o_ic_addr),
        .o_uncached    (),          // icache serves both kinds
        .o_miss        (o_imiss)
    );

    addr_translate u_dtrans (
        .i_vaddr       (d_cpu.addr),
        .i_k0_uncached (i_k0_uncached),
        .i_hit         (dhit),
        .i_entry       (dentry),
        .o_vpn2        (dvpn2),
        .o_paddr       (dpaddr),
        .o_uncached    (duncached),
        .o_miss        (o_dmiss)
    );

    dmem_dispatch u_dispatch (
        .clk        (clk),
        .resetn     (resetn),
        .cpu        (d_cpu.slave),
        .dcache     (d_cache.master),
        .uncached   (d_unc.master),
        .i_paddr    (dpaddr),
        .i_uncached (duncached)
    );

endmodule

// File: bench/mem_responder.sv
`timescale 1ns/1ns

module mem_responder #(
    parameter mmu_pkg::word_t TAG  = 32'h0,
    parameter logic [31:0]    SEED = 32'ha976_323b
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic           i_req,
    input  mmu_pkg::word_t i_addr,
    output logic           o_addr_ok,
    output logic           o_data_ok,
    output mmu_pkg::word_t o_rdata
);
    import mmu_pkg::*;

    logic [31:0] lfsr = SEED;
    word_t       pending [$];   // rdata of accepted requests, oldest first
    logic [1:0]  gap;           // cycles left before the next data_ok

    // galois lfsr, one step per bit taken
    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return b;
    endfunction

    initial begin
        o_addr_ok <= 1'b0;
        o_data_ok <= 1'b0;
        o_rdata   <= '0;
    end

    always @(posedge clk) begin
        if (resetn) begin
            pending.delete();
            gap = 2'd0;
            o_addr_ok <= 1'b0;
            o_data_ok <= 1'b0;
            o_rdata   <= '0;
        end else begin
            if (i_req && o_addr_ok) begin
                pending.push_back(i_addr ^ TAG);    // tag tells the targets apart
            end
            o_data_ok <= 1'b0;
            if (pending.size() > 0) begin
                if (gap == 2'd0) begin
                    o_data_ok <= 1'b1;
                    o_rdata   <= pending.pop_front();
                    gap[0] = take_bit();
                    gap[1] = take_bit();
                end else begin
                    gap = gap - 2'd1;
                end
            end
            o_addr_ok <= take_bit();    // random back-pressure
        end
    end

endmodule

// File: bench/mmu_tb.sv
`timescale 1ns/1ns

module mmu_tb;
    import mmu_pkg::*;

    localparam int    N_ENTRIES  = 8;
    localparam int    IDX_W      = $clog2(N_ENTRIES);
    localparam int    N_RANDOM   = 200;
    localparam int    N_DIRECTED = 50;
    localparam int    MAX_CYCLES = (N_RANDOM + N_DIRECTED) * 16;   // 16 cycles per access
    localparam word_t IC_TAG     = 32'h1C1C_0000;
    localparam word_t DC_TAG     = 32'hDC00_00DC;
    localparam word_t UC_TAG     = 32'h0C0C_0C0C;
    localparam word_t MAPPED_VA [6] = '{32'h0002_0010, 32'h0002_1ABC, 32'h0004_0020,
                                        32'h0004_1020, 32'h6000_1ABC, 32'h0100_0000};

    typedef struct packed {
        word_t paddr;
        logic  uncached;
        logic  miss;
    } xlate_t;

    logic             clk, resetn, i_k0_uncached;
    logic             i_ireq, o_iaddr_ok, o_idata_ok, o_imiss;
    word_t            i_iaddr, o_irdata;
    logic             i_dreq, i_dwr, o_daddr_ok, o_ddata_ok, o_dmiss;
    logic [1:0]       i_dsize, o_dc_size, o_uc_size;
    word_t            i_daddr, i_dwdata, o_drdata;
    logic             o_ic_req, i_ic_addr_ok, i_ic_data_ok;
    word_t            o_ic_addr, i_ic_rdata;
    logic             o_dc_req, o_dc_wr, i_dc_addr_ok, i_dc_data_ok;
    word_t            o_dc_addr, o_dc_wdata, i_dc_rdata;
    logic             o_uc_req, o_uc_wr, i_uc_addr_ok, i_uc_data_ok;
    word_t            o_uc_addr, o_uc_wdata, i_uc_rdata;
    asid_t            i_asid;
    tlb_op_e          i_tlb_op;
    logic [IDX_W-1:0] i_tlb_index, o_tlbp_index;
    tlb_entry_t       i_tlb_entry, o_tlbr_entry;
    logic             o_tlbp_found;

    logic [31:0] lfsr = 32'ha976_323b;
    tlb_entry_t  shadow [N_ENTRIES];    // what the TLB should hold
    word_t       exp_q [$];             // expected rdata in acceptance order
    int          n_errors = 0, n_checks = 0, cycles = 0;
    int          n_accepted = 0, n_returned = 0, n_targeted = 0;
    int          dc_busy = 0, uc_busy = 0;

    mmu_top #(.TLB_ENTRIES(N_ENTRIES)) u_mmu_top (.*);

    mem_responder #(.TAG(IC_TAG)) u_icache (
        .clk(clk), .resetn(resetn), .i_req(o_ic_req), .i_addr(o_ic_addr),
        .o_addr_ok(i_ic_addr_ok), .o_data_ok(i_ic_data_ok), .o_rdata(i_ic_rdata));
    mem_responder #(.TAG(DC_TAG)) u_dcache (
        .clk(clk), .resetn(resetn), .i_req(o_dc_req), .i_addr(o_dc_addr),
        .o_addr_ok(i_dc_addr_ok), .o_data_ok(i_dc_data_ok), .o_rdata(i_dc_rdata));
    mem_responder #(.TAG(UC_TAG)) u_uncached (
        .clk(clk), .resetn(resetn), .i_req(o_uc_req), .i_addr(o_uc_addr),
        .o_addr_ok(i_uc_addr_ok), .o_data_ok(i_uc_data_ok), .o_rdata(i_uc_rdata));

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic entry_hits(input tlb_entry_t e, input vpn2_t vpn2, input asid_t asid);
        return (e.vpn2 == vpn2) && (e.g || e.asid == asid);
    endfunction

    // segment map plus shadow TLB lookup
    function automatic xlate_t translate_ref(input word_t va);
        xlate_t     x;
        tlb_entry_t e;
        logic       hit;
        x.paddr    = {3'b000, va[28:0]};
        x.uncached = 1'b1;
        x.miss     = 1'b0;
        hit        = 1'b0;
        e          = '0;
        if (va[31:29] == 3'b100) begin
            x.uncached = i_k0_uncached;     // kseg0
        end else if (va[31:29] != 3'b101) begin
            for (int k = 0; k < N_ENTRIES; k++) begin
                if (entry_hits(shadow[k], va[31:13], i_asid)) begin
                    hit = 1'b1;
                    e   = shadow[k];
                end
            end
            if (hit && (va[12] ? e.v1 : e.v0)) begin
                x.paddr    = va[12] ? {e.pfn1, va[11:0]} : {e.pfn0, va[11:0]};
                x.uncached = (va[12] ? e.c1 : e.c0) != K0_CACHED;
            end else begin
                x.miss = 1'b1;
            end
        end
        return x;
    endfunction

    function automatic word_t expected_drdata(input word_t va);
        xlate_t x;
        x = translate_ref(va);
        return x.paddr ^ (x.uncached ? UC_TAG : DC_TAG);
    endfunction

    function automatic int probe_ref(input vpn2_t vpn2, input asid_t asid);
        int idx;
        idx = -1;
        for (int k = 0; k < N_ENTRIES; k++) begin
            if (entry_hits(shadow[k], vpn2, asid)) begin
                idx = k;
            end
        end
        return idx;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_entry(input string name, input tlb_entry_t got, input tlb_entry_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // wr, size and wdata pass unchanged from the cpu data bus
    task automatic check_forwarded(input string target, input logic wr, input logic [1:0] size,
                                   input word_t wdata);
        check_bit({target, "_wr"}, wr, i_dwr);
        check_word({target, "_size"}, word_t'(size), word_t'(i_dsize));
        check_word({target, "_wdata"}, wdata, i_dwdata);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run still busy after %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // data side scoreboard and target conflict monitor
    always @(posedge clk) begin
        if (!resetn) begin
            if (o_ddata_ok) begin
                n_returned++;
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("data_ok at %0t with no data request outstanding", $time);
                end else begin
                    check_word("o_drdata", o_drdata, exp_q.pop_front());
                end
            end
            if (i_dreq && o_daddr_ok) begin
                n_accepted++;
                exp_q.push_back(expected_drdata(i_daddr));
            end
            if (o_dc_req) begin
                check_forwarded("o_dc", o_dc_wr, o_dc_size, o_dc_wdata);
            end
            if (o_uc_req) begin
                check_forwarded("o_uc", o_uc_wr, o_uc_size, o_uc_wdata);
            end
            if ((o_uc_req && dc_busy > 0) || (o_dc_req && uc_busy > 0)) begin
                n_errors++;
                $display("target switched at %0t while the other target owed data", $time);
            end
            n_targeted = n_targeted + int'(o_dc_req && i_dc_addr_ok)
                                    + int'(o_uc_req && i_uc_addr_ok);
            dc_busy = dc_busy + int'(o_dc_req && i_dc_addr_ok) - int'(i_dc_data_ok);
            uc_busy = uc_busy + int'(o_uc_req && i_uc_addr_ok) - int'(i_uc_data_ok);
        end
    end

    // leaves req high for the caller to drop
    task automatic issue_dreq(input word_t va);
        xlate_t x;
        i_dreq   <= 1'b1;
        i_daddr  <= va;
        i_dwr    <= 1'(rand_bits(1));
        i_dsize  <= 2'(rand_bits(2));
        i_dwdata <= rand_bits(32);
        @(posedge clk);
        x = translate_ref(va);
        check_bit("o_dmiss", o_dmiss, x.miss);
        while (!o_daddr_ok) @(posedge clk);
    endtask

    task automatic wait_drained();
        do @(negedge clk); while (n_returned != n_accepted);
        @(posedge clk);
    endtask

    task automatic send_dreq(input word_t va);
        issue_dreq(va);
        i_dreq <= 1'b0;
        wait_drained();
    endtask

    task automatic send_ireq(input word_t va);
        xlate_t x;
        i_ireq  <= 1'b1;
        i_iaddr <= va;
        @(posedge clk);
        x = translate_ref(va);
        check_word("o_ic_addr", o_ic_addr, x.paddr);
        check_bit("o_imiss", o_imiss, x.miss);
        while (!o_iaddr_ok) @(posedge clk);
        i_ireq <= 1'b0;
        do @(posedge clk); while (!o_idata_ok);
        check_word("o_irdata", o_irdata, x.paddr ^ IC_TAG);
    endtask

    task automatic tlb_write(input int idx, input tlb_entry_t e);
        i_tlb_op    <= TLB_WRITE;
        i_tlb_index <= IDX_W'(idx);
        i_tlb_entry <= e;
        @(posedge clk);
        i_tlb_op <= TLB_NOP;
        shadow[idx] = e;
    endtask

    task automatic tlb_read(input int idx);
        i_tlb_op    <= TLB_READ;
        i_tlb_index <= IDX_W'(idx);
        @(posedge clk);
        i_tlb_op <= TLB_NOP;
        @(posedge clk);     // registered result is valid now
        check_entry("o_tlbr_entry", o_tlbr_entry, shadow[idx]);
    endtask

    task automatic tlb_probe(input vpn2_t vpn2, input asid_t asid);
        tlb_entry_t key;
        int         idx;
        key      = '0;
        key.vpn2 = vpn2;
        key.asid = asid;
        idx      = probe_ref(vpn2, asid);
        i_tlb_op    <= TLB_PROBE;
        i_tlb_entry <= key;
        @(posedge clk);
        i_tlb_op <= TLB_NOP;
        @(posedge clk);
        check_bit("o_tlbp_found", o_tlbp_found, idx >= 0);
        if (idx >= 0) begin
            check_word("o_tlbp_index", word_t'(o_tlbp_index), word_t'(idx));
        end
    endtask

    initial begin
        tlb_entry_t e;
        word_t      va;
        logic [1:0] sel;
        for (int k = 0; k < N_ENTRIES; k++) begin
            shadow[k] = '0;
        end
        resetn        <= 1'b1;
        i_k0_uncached <= 1'b0;
        i_ireq        <= 1'b0;
        i_iaddr       <= '0;
        i_dreq        <= 1'b0;
        i_dwr         <= 1'b0;
        i_dsize       <= 2'd2;
        i_daddr       <= '0;
        i_dwdata      <= '0;
        i_asid        <= 8'h05;
        i_tlb_op      <= TLB_NOP;
        i_tlb_index   <= '0;
        i_tlb_entry   <= '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b0;
        @(posedge clk);

        // unmapped segments
        send_ireq(32'h8000_1234);
        send_ireq(32'hBFC0_0380);
        send_dreq(32'h8000_0100);
        send_dreq(32'h9FFF_FFFC);
        send_dreq(32'hA000_0200);
        send_dreq(32'hBFC0_0010);
        i_k0_uncached <= 1'b1;
        send_dreq(32'h8000_0300);
        send_ireq(32'h8000_0400);
        i_k0_uncached <= 1'b0;

        // TLB write and read back with entry 7 left at its reset value
        e = '{vpn2: 19'h00010, asid: 8'h05, g: 1'b0, pfn0: 20'h12345, c0: 3'd3, v0: 1'b1,
              pfn1: 20'h23456, c1: 3'd2, v1: 1'b1};
        tlb_write(0, e);
        e = '{vpn2: 19'h00020, asid: 8'h22, g: 1'b1, pfn0: 20'h0ABCD, c0: 3'd3, v0: 1'b1,
              pfn1: 20'h0DEAD, c1: 3'd3, v1: 1'b0};
        tlb_write(3, e);
        e = '{vpn2: 19'h30000, asid: 8'h05, g: 1'b0, pfn0: 20'h00555, c0: 3'd2, v0: 1'b1,
              pfn1: 20'h00777, c1: 3'd3, v1: 1'b1};
        tlb_write(5, e);
        tlb_read(0);
        tlb_read(3);
        tlb_read(5);
        tlb_read(7);

        // probe a plain hit, a global hit, an asid mismatch and an absent pair
        tlb_probe(19'h00010, 8'h05);
        tlb_probe(19'h00020, 8'h99);
        tlb_probe(19'h00010, 8'h06);
        tlb_probe(19'h7ABCD, 8'h05);

        // mapped translation on both pages including misses
        for (int k = 0; k < 6; k++) begin
            send_ireq(MAPPED_VA[k]);
            send_dreq(MAPPED_VA[k]);
        end
        i_asid <= 8'h06;
        send_dreq(32'h0002_0010);   // miss under another asid
        send_dreq(32'h0004_0020);   // global still hits
        i_asid <= 8'h05;

        // random mixed stream that runs back to back where the lfsr allows
        for (int n = 0; n < N_RANDOM; n++) begin
            sel = 2'(rand_bits(2));
            va  = rand_bits(12) & 32'h0000_0FFC;
            case (sel)
                2'd0: va = va | 32'h0002_0000;  // mapped cached page
                2'd1: va = va | 32'h0002_1000;  // mapped uncached page
                2'd2: va = va | 32'h8010_0000;
                2'd3: va = va | 32'hA010_0000;
            endcase
            issue_dreq(va);
            if (rand_bits(1) != 0) begin
                i_dreq <= 1'b0;
                @(posedge clk);
            end
        end
        i_dreq <= 1'b0;
        wait_drained();

        if (n_targeted != n_accepted) begin
            n_errors++;
            $display("targets took %0d requests for %0d accepted data requests",
                     n_targeted, n_accepted);
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: files.f
src/mmu_pkg.sv
src/mem_bus_if.sv
src/tlb.sv
src/addr_translate.sv
src/dmem_dispatch.sv
src/mmu_top.sv
bench/mem_responder.sv
bench/mmu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module mmu_tb -f files.f -o mmu_sim
./obj_dir/mmu_sim | tee sim.log
if grep -q "^All tests passed!$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
